// ==== hdl/md5_pkg.sv ====
`default_nettype none

package md5_pkg;

  localparam int BUS_W = 64;
  localparam int MD5_W = 32;

  localparam int BLOCK_READS   = 8;
  localparam int MD5_ROUNDS    = 64;
  localparam int DIGEST_WRITES = 2;

  typedef logic [BUS_W-1:0] bus_word_t;
  typedef logic [BUS_W-1:0] addr_t;
  typedef logic [MD5_W-1:0] md5_word_t;
  typedef logic [$clog2(MD5_ROUNDS)-1:0] round_t;

  // w[0] sits in the low 32 bits, so w[i] is message word i
  typedef struct packed {
    md5_word_t [15:0] w;
  } md5_block_t;

  typedef struct packed {
    md5_word_t a;
    md5_word_t b;
    md5_word_t c;
    md5_word_t d;
  } md5_state_t;

  typedef enum logic [1:0] {FUNC_F, FUNC_G, FUNC_H, FUNC_I} md5_func_e;

  typedef enum logic [1:0] {FETCH_IDLE, FETCH_WAIT, FETCH_DEAL, FETCH_DONE} fetch_state_e;

  typedef enum logic [1:0] {STORE_IDLE, STORE_WAIT, STORE_DEAL, STORE_DONE} store_state_e;

  localparam md5_state_t MD5_INIT = '{
    a: 32'h67452301,
    b: 32'hefcdab89,
    c: 32'h98badcfe,
    d: 32'h10325476
  };

  localparam md5_word_t ROUND_K [MD5_ROUNDS] = '{
    32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
    32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
    32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
    32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
    32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
    32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
    32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
    32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
    32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
    32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
    32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
    32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
    32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
    32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
    32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
    32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
  };

  // the rotate amount repeats every four rounds within a group
  localparam logic [4:0] ROUND_S [16] = '{
    5'd7, 5'd12, 5'd17, 5'd22,
    5'd5, 5'd9,  5'd14, 5'd20,
    5'd4, 5'd11, 5'd16, 5'd23,
    5'd6, 5'd10, 5'd15, 5'd21
  };

  function automatic md5_func_e round_func(input round_t round);
    return md5_func_e'(round[5:4]);
  endfunction

  function automatic md5_word_t round_constant(input round_t round);
    return ROUND_K[round];
  endfunction

  function automatic logic [4:0] round_shift(input round_t round);
    return ROUND_S[{round[5:4], round[1:0]}];
  endfunction

  // index arithmetic wraps mod 16, so only the low four round bits matter
  function automatic logic [3:0] round_msg_index(input round_t round);
    logic [3:0] i;
    i = round[3:0];
    case (round_func(round))
      FUNC_F:  return i;
      FUNC_G:  return 4'(5 * i + 1);
      FUNC_H:  return 4'(3 * i + 5);
      default: return 4'(7 * i);
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== hdl/block_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

module block_fetch
  import md5_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  addr_t      read_base,
  input  addr_t      stride,
  input  bus_word_t  read_data,
  input  logic       read_ready,
  output logic       read_enable,
  output addr_t      read_addr,
  output logic       finish_read,
  output md5_block_t block,
  output logic       block_valid
);

  fetch_state_e state;
  logic [2:0]   read_cnt;
  logic         accept;

  assign accept = (state == FETCH_WAIT) && read_ready;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state       <= FETCH_IDLE;
      read_cnt    <= '0;
      read_enable <= 1'b0;
      read_addr   <= '0;
      finish_read <= 1'b0;
      block_valid <= 1'b0;
    end
    else
    begin
      case (state)
        FETCH_IDLE:
        begin
          read_enable <= 1'b1;
          read_addr   <= read_base;
          state       <= FETCH_WAIT;
        end
        FETCH_WAIT:
        begin
          finish_read <= 1'b0;
          if (accept)
          begin
            state <= FETCH_DEAL;
          end
        end
        FETCH_DEAL:
        begin
          if (read_cnt != 3'(BLOCK_READS - 1))
          begin
            read_cnt    <= read_cnt + 3'd1;
            read_addr   <= read_addr + stride;
            finish_read <= 1'b1;
            state       <= FETCH_WAIT;
          end
          else
          begin
            // the last word is captured so the block goes to the core
            read_enable <= 1'b0;
            block_valid <= 1'b1;
            state       <= FETCH_DONE;
          end
        end
        default:
        begin
          block_valid <= 1'b0;
        end
      endcase
    end
  end

  // read word k fills message words 2k (low half) and 2k+1 (high half)
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      block.w[{read_cnt, 1'b0}] <= read_data[MD5_W-1:0];
      block.w[{read_cnt, 1'b1}] <= read_data[BUS_W-1:MD5_W];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/md5_compress.sv ====
`timescale 1ns/1ns
`default_nettype none

module md5_compress
  import md5_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  md5_block_t block,
  input  logic       block_valid,
  output md5_state_t digest,
  output logic       digest_valid
);

  md5_state_t st;
  md5_state_t step;
  md5_block_t msg;
  round_t     round;
  logic       busy;
  logic       last_round;

  md5_word_t   f;
  md5_word_t   sum;
  logic [63:0] dbl;

  assign last_round = busy && (round == round_t'(MD5_ROUNDS - 1));

  // one md5 round on the current working state
  always_comb
  begin
    case (round_func(round))
      FUNC_F: f = (st.b & st.c) | (~st.b & st.d);
      FUNC_G: f = (st.d & st.b) | (~st.d & st.c);
      FUNC_H: f = st.b ^ st.c ^ st.d;
      FUNC_I: f = st.c ^ (st.b | ~st.d);
    endcase
    sum = st.a + f + round_constant(round) + msg.w[round_msg_index(round)];
    // the upper half of the doubled word shifted left is the left rotate
    dbl = {sum, sum} << round_shift(round);
    step.a = st.d;
    step.b = st.b + dbl[63:32];
    step.c = st.b;
    step.d = st.c;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      busy         <= 1'b0;
      round        <= '0;
      digest_valid <= 1'b0;
    end
    else
    begin
      digest_valid <= last_round;
      if (block_valid)
      begin
        busy  <= 1'b1;
        round <= '0;
      end
      else if (busy)
      begin
        round <= round + round_t'(1);
        if (last_round)
        begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (block_valid)
    begin
      st  <= MD5_INIT;
      msg <= block;
    end
    else if (last_round)
    begin
      // feed-forward of the initial values closes the block
      st.a <= step.a + MD5_INIT.a;
      st.b <= step.b + MD5_INIT.b;
      st.c <= step.c + MD5_INIT.c;
      st.d <= step.d + MD5_INIT.d;
    end
    else if (busy)
    begin
      st <= step;
    end
  end

  // the state stays put once the rounds are over
  assign digest = st;

endmodule

`default_nettype wire

// ==== hdl/digest_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module digest_store
  import md5_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  addr_t      write_base,
  input  addr_t      stride,
  input  md5_state_t digest,
  input  logic       digest_valid,
  input  logic       write_ready,
  output logic       write_enable,
  output addr_t      write_addr,
  output bus_word_t  write_data,
  output logic       finish_write,
  output logic       done
);

  store_state_e state;
  logic         write_cnt;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state        <= STORE_IDLE;
      write_cnt    <= 1'b0;
      write_enable <= 1'b0;
      write_addr   <= '0;
      write_data   <= '0;
      finish_write <= 1'b0;
      done         <= 1'b0;
    end
    else
    begin
      case (state)
        STORE_IDLE:
        begin
          if (digest_valid)
          begin
            write_enable <= 1'b1;
            write_addr   <= write_base;
            write_data   <= {digest.b, digest.a};
            state        <= STORE_WAIT;
          end
        end
        STORE_WAIT:
        begin
          finish_write <= 1'b0;
          if (write_ready)
          begin
            state <= STORE_DEAL;
          end
        end
        STORE_DEAL:
        begin
          if (write_cnt != 1'(DIGEST_WRITES - 1))
          begin
            write_cnt    <= write_cnt + 1'b1;
            write_addr   <= write_addr + stride;
            write_data   <= {digest.d, digest.c};
            finish_write <= 1'b1;
            state        <= STORE_WAIT;
          end
          else
          begin
            write_enable <= 1'b0;
            done         <= 1'b1;
            state        <= STORE_DONE;
          end
        end
        default:
        begin
          // parked here with done high until the next reset
          state <= STORE_DONE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/md5_block_hasher.sv ====
`timescale 1ns/1ns
`default_nettype none

module md5_block_hasher
  import md5_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  addr_t     read_base,
  input  addr_t     write_base,
  input  addr_t     stride,
  input  bus_word_t read_data,
  input  logic      read_ready,
  input  logic      write_ready,
  output logic      read_enable,
  output addr_t     read_addr,
  output logic      finish_read,
  output logic      write_enable,
  output addr_t     write_addr,
  output bus_word_t write_data,
  output logic      finish_write,
  output logic      done
);

  md5_block_t block;
  logic       block_valid;
  md5_state_t digest;
  logic       digest_valid;

  block_fetch i_block_fetch (
    .clk         (clk),
    .reset       (reset),
    .read_base   (read_base),
    .stride      (stride),
    .read_data   (read_data),
    .read_ready  (read_ready),
    .read_enable (read_enable),
    .read_addr   (read_addr),
    .finish_read (finish_read),
    .block       (block),
    .block_valid (block_valid)
  );

  md5_compress i_md5_compress (
    .clk          (clk),
    .reset        (reset),
    .block        (block),
    .block_valid  (block_valid),
    .digest       (digest),
    .digest_valid (digest_valid)
  );

  digest_store i_digest_store (
    .clk          (clk),
    .reset        (reset),
    .write_base   (write_base),
    .stride       (stride),
    .digest       (digest),
    .digest_valid (digest_valid),
    .write_ready  (write_ready),
    .write_enable (write_enable),
    .write_addr   (write_addr),
    .write_data   (write_data),
    .finish_write (finish_write),
    .done         (done)
  );

endmodule

`default_nettype wire

// ==== sim/md5_block_hasher_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module md5_block_hasher_checker
  import md5_pkg::*;
(
  input logic      clk,
  input logic      reset,
  input logic      read_enable,
  input addr_t     read_addr,
  input logic      read_ready,
  input logic      finish_read,
  input logic      write_enable,
  input addr_t     write_addr,
  input bus_word_t write_data,
  input logic      write_ready,
  input logic      finish_write,
  input logic      done
);

  int fail_count = 0;

  assert property (@(posedge clk) disable iff (reset) !(read_enable && write_enable))
  else
  begin
    fail_count++;
    $error("read_enable and write_enable are high together");
  end

  assert property (@(posedge clk) disable iff (reset) finish_read |=> !finish_read)
  else
  begin
    fail_count++;
    $error("finish_read lasts more than one cycle");
  end

  assert property (@(posedge clk) disable iff (reset) finish_write |=> !finish_write)
  else
  begin
    fail_count++;
    $error("finish_write lasts more than one cycle");
  end

  // the cycle right after an accepted read is the step cycle, where the address may move
  assert property (@(posedge clk) disable iff (reset)
    read_enable && !read_ready && !$past(read_ready) |=> $stable(read_addr) && read_enable)
  else
  begin
    fail_count++;
    $error("read request changed while the memory was not ready");
  end

  assert property (@(posedge clk) disable iff (reset)
    write_enable && !write_ready && !$past(write_ready)
      |=> $stable(write_addr) && $stable(write_data) && write_enable)
  else
  begin
    fail_count++;
    $error("write request changed while the memory was not ready");
  end

  assert property (@(posedge clk) disable iff (reset) done |-> !read_enable && !write_enable)
  else
  begin
    fail_count++;
    $error("an enable is high while done is set");
  end

endmodule

`default_nettype wire

// ==== include/md5_ref.svh ====
`ifndef MD5_REF_SVH
`define MD5_REF_SVH

// software model of a single md5 compression from the standard initial values
function automatic md5_pkg::md5_state_t md5_ref(input md5_pkg::md5_block_t blk);
  md5_pkg::md5_state_t st;
  md5_pkg::md5_state_t res;
  md5_pkg::md5_word_t  f;
  md5_pkg::md5_word_t  sum;
  md5_pkg::round_t     r;
  logic [4:0]          s;
  st = md5_pkg::MD5_INIT;
  for (int i = 0; i < md5_pkg::MD5_ROUNDS; i++)
  begin
    r = md5_pkg::round_t'(i);
    case (md5_pkg::round_func(r))
      md5_pkg::FUNC_F: f = (st.b & st.c) | (~st.b & st.d);
      md5_pkg::FUNC_G: f = (st.d & st.b) | (~st.d & st.c);
      md5_pkg::FUNC_H: f = st.b ^ st.c ^ st.d;
      default:         f = st.c ^ (st.b | ~st.d);
    endcase
    sum = st.a + f + md5_pkg::round_constant(r) + blk.w[md5_pkg::round_msg_index(r)];
    s = md5_pkg::round_shift(r);
    st.a = st.d;
    st.d = st.c;
    st.c = st.b;
    st.b = st.b + ((sum << s) | (sum >> (32 - s)));
  end
  res.a = st.a + md5_pkg::MD5_INIT.a;
  res.b = st.b + md5_pkg::MD5_INIT.b;
  res.c = st.c + md5_pkg::MD5_INIT.c;
  res.d = st.d + md5_pkg::MD5_INIT.d;
  return res;
endfunction

`endif

// ==== sim/tb_md5_block_hasher.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_md5_block_hasher
  import md5_pkg::*;
();

  // five tests take at most about 175 cycles each and the back-pressure test about 335
  localparam int TIMEOUT_CYCLES = 1500;

  logic      clk = 1'b0;
  logic      reset = 1'b1;
  addr_t     read_base = '0;
  addr_t     write_base = '0;
  addr_t     stride = 64'd8;
  bus_word_t read_data = '0;
  logic      read_ready = 1'b0;
  logic      write_ready = 1'b0;
  logic      read_enable;
  logic      finish_read;
  logic      write_enable;
  logic      finish_write;
  logic      done;
  addr_t     read_addr;
  addr_t     write_addr;
  bus_word_t write_data;

  integer    seed = 32'h148b;
  bus_word_t mem [BLOCK_READS];
  int        delay_min = 0;
  int        rd_delay;
  int        wr_delay;
  logic      rd_skip;
  logic      wr_skip;
  addr_t     rd_addrs [$];
  addr_t     wr_addrs [$];
  bus_word_t wr_data [$];
  int        finish_reads;
  int        finish_writes;
  int        errors = 0;
  int        cycles = 0;

  `include "md5_ref.svh"

  md5_block_hasher i_md5_block_hasher (
    .clk(clk), .reset(reset), .read_base(read_base), .write_base(write_base),
    .stride(stride), .read_data(read_data), .read_ready(read_ready),
    .write_ready(write_ready), .read_enable(read_enable), .read_addr(read_addr),
    .finish_read(finish_read), .write_enable(write_enable), .write_addr(write_addr),
    .write_data(write_data), .finish_write(finish_write), .done(done)
  );

  bind md5_block_hasher md5_block_hasher_checker i_checker (
    .clk(clk), .reset(reset), .read_enable(read_enable), .read_addr(read_addr),
    .read_ready(read_ready), .finish_read(finish_read), .write_enable(write_enable),
    .write_addr(write_addr), .write_data(write_data), .write_ready(write_ready),
    .finish_write(finish_write), .done(done)
  );

  initial
  begin
    forever #50 clk = ~clk;
  end

  function automatic int next_delay();
    int r;
    r = $random(seed);
    return delay_min + ((r & 32'h7fffffff) % 8);
  endfunction

  // the memory model answers each request after a random number of cycles
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (reset)
    begin
      read_ready    <= 1'b0;
      write_ready   <= 1'b0;
      rd_skip       <= 1'b0;
      wr_skip       <= 1'b0;
      rd_delay      <= next_delay();
      wr_delay      <= next_delay();
      finish_reads  <= 0;
      finish_writes <= 0;
    end
    else
    begin
      if (finish_read)
        finish_reads <= finish_reads + 1;
      if (finish_write)
        finish_writes <= finish_writes + 1;
      // the cycle after an accept is the step cycle, so ready stays low through it
      if (read_ready || rd_skip)
      begin
        read_ready <= 1'b0;
        rd_skip    <= read_ready;
        rd_delay   <= next_delay();
      end
      else if (read_enable && rd_delay == 0)
      begin
        read_ready <= 1'b1;
        read_data  <= mem[3'((read_addr - read_base) / stride)];
        rd_addrs.push_back(read_addr);
      end
      else if (read_enable)
        rd_delay <= rd_delay - 1;
      if (write_ready || wr_skip)
      begin
        write_ready <= 1'b0;
        wr_skip     <= write_ready;
        wr_delay    <= next_delay();
      end
      else if (write_enable && wr_delay == 0)
      begin
        write_ready <= 1'b1;
        wr_addrs.push_back(write_addr);
        wr_data.push_back(write_data);
      end
      else if (write_enable)
        wr_delay <= wr_delay - 1;
    end
    if (cycles == TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, the DUT never raised done", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    assert (actual === expected)
    else
    begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic run_test(input string name, input addr_t rbase, input addr_t wbase,
                          input addr_t step, input int dmin, input logic known);
    md5_block_t blk;
    md5_state_t exp;
    bus_word_t  exp_first;
    bus_word_t  exp_second;
    for (int k = 0; k < BLOCK_READS; k++)
    begin
      blk.w[4'(2 * k)]     = mem[3'(k)][31:0];
      blk.w[4'(2 * k + 1)] = mem[3'(k)][63:32];
    end
    exp        = md5_ref(blk);
    exp_first  = known ? 64'h04b2008fd98c1dd4 : {exp.b, exp.a};
    exp_second = known ? 64'h7e42f8ec980980e9 : {exp.d, exp.c};
    delay_min  = dmin;
    @(posedge clk);
    reset      <= 1'b1;
    read_base  <= rbase;
    write_base <= wbase;
    stride     <= step;
    rd_addrs.delete();
    wr_addrs.delete();
    wr_data.delete();
    repeat (3) @(posedge clk);
    check({name, " outputs in reset"}, 64'h0,
          {59'd0, read_enable, write_enable, finish_read, finish_write, done});
    reset <= 1'b0;
    repeat (2) @(posedge clk);
    check({name, " first read_enable"}, 64'd1, 64'(read_enable));
    check({name, " first read_addr"}, rbase, read_addr);
    while (!done)
      @(posedge clk);
    repeat (4)
    begin
      @(posedge clk);
      check({name, " done held, enables low"}, 64'h4,
            {61'd0, done, read_enable, write_enable});
    end
    check({name, " read count"}, 64'd8, 64'(rd_addrs.size()));
    for (int k = 0; k < rd_addrs.size() && k < BLOCK_READS; k++)
      check({name, " read_addr"}, rbase + addr_t'(k) * step, rd_addrs[k]);
    check({name, " finish_read pulses"}, 64'd7, 64'(finish_reads));
    check({name, " finish_write pulses"}, 64'd1, 64'(finish_writes));
    check({name, " write count"}, 64'd2, 64'(wr_addrs.size()));
    if (wr_addrs.size() == 2)
    begin
      check({name, " first write_addr"}, wbase, wr_addrs[0]);
      check({name, " second write_addr"}, wbase + step, wr_addrs[1]);
      check({name, " first digest word"}, exp_first, wr_data[0]);
      check({name, " second digest word"}, exp_second, wr_data[1]);
    end
  endtask

  initial
  begin
    for (int k = 0; k < BLOCK_READS; k++)
      mem[3'(k)] = (k == 0) ? 64'h80 : 64'h0;
    run_test("known vector", 64'h1000, 64'h2000, 64'd8, 0, 1'b1);
    for (int t = 0; t < 4; t++)
    begin
      for (int k = 0; k < BLOCK_READS; k++)
        mem[3'(k)] = {$random(seed), $random(seed)};
      run_test("random block", {$random(seed), $random(seed)}, {$random(seed), $random(seed)},
               64'($random(seed) & 32'hfff8) + 64'd8, 0, 1'b0);
    end
    // empty message again with every ready held off for 16 to 23 cycles
    for (int k = 0; k < BLOCK_READS; k++)
      mem[3'(k)] = (k == 0) ? 64'h80 : 64'h0;
    run_test("back-pressure", {$random(seed), $random(seed)}, {$random(seed), $random(seed)},
             64'd24, 16, 1'b1);
    $display("errors: %0d failed checks, %0d failed assertions", errors,
             i_md5_block_hasher.i_checker.fail_count);
    if (errors == 0 && i_md5_block_hasher.i_checker.fail_count == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
hdl/md5_pkg.sv
hdl/block_fetch.sv
hdl/md5_compress.sv
hdl/digest_store.sv
hdl/md5_block_hasher.sv
sim/md5_block_hasher_checker.sv
sim/tb_md5_block_hasher.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_md5_block_hasher -f all.f
output=$(./obj_dir/Vtb_md5_block_hasher +verilator+error+limit+100) || true
echo "$output"
if echo "$output" | grep -q "Simulation PASSED"
then
  exit 0
else
  exit 1
fi
